// File: dv/tb_alu_core.sv
// tb_alu_core testbench for the multicycle alu core
// random and directed programs against an isa reference model
`default_nettype none

module tb_alu_core;
  timeunit 1ns;
  timeprecision 100ps;
  import isa_pkg::*;
  import core_pkg::*;

  localparam int TIMEOUT_CYCLES = 50;
  localparam int WB_SPACING     = 3;
  localparam int NUM_RAND_PROGS = 24;
  localparam int WORD_MAX       = 2 ** (BW - 1) - 1;
  localparam int WORD_MIN       = -(2 ** (BW - 1));

  logic     clk;
  logic     rst_n;
  logic     prog_we;
  pc_t      prog_addr;
  instr_t   prog_data;
  pc_t      prog_len;
  logic     start;
  logic     busy;
  logic     wb_valid;
  reg_idx_t wb_reg;
  word_t    wb_data;
  flags_t   wb_flags;
  logic     done;

  int cycle_cnt = 0;
  int checks    = 0;
  int errors    = 0;
  int timeouts  = 0;
  // model registers persist across runs, same as the DUT
  word_t model_regs [4];

  alu_core #(
    .BW         (BW),
    .PROG_DEPTH (PROG_DEPTH)
  ) alu_core_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .prog_len  (prog_len),
    .start     (start),
    .busy      (busy),
    .wb_valid  (wb_valid),
    .wb_reg    (wb_reg),
    .wb_data   (wb_data),
    .wb_flags  (wb_flags),
    .done      (done)
  );

  // 4 ns period
  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // -------------------------------------------------------------------
  // helpers
  // -------------------------------------------------------------------
  // drive and sample 1 ns after the rising edge
  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  function automatic instr_t encode(input opcode_t op, input reg_idx_t rd, input reg_idx_t ra,
                                    input bit use_imm, input logic [7:0] imm_or_rb);
    return {op, rd, ra, use_imm, imm_or_rb};
  endfunction

  // random start and program writes while a program runs
  task automatic drive_noise(input bit en);
    if (en && busy && !done) begin
      start     = 1'b1;
      prog_we   = 1'b1;
      prog_addr = pc_t'($urandom);
      prog_data = instr_t'($urandom);
    end else begin
      start   = 1'b0;
      prog_we = 1'b0;
    end
  endtask

  // -------------------------------------------------------------------
  // reference model
  // -------------------------------------------------------------------
  // fields: op[15:13] rd[12:11] ra[10:9] use_imm[8] imm_or_rb[7:0]
  task automatic model_exec(input instr_t ins, output reg_idx_t exp_reg,
                            output word_t exp_data, output flags_t exp_flags);
    opcode_t op;
    word_t   a;
    word_t   b;
    int      wide;
    bit      arith;
    bit      ovf;
    op      = ins[15:13];
    exp_reg = ins[12:11];
    a       = model_regs[ins[10:9]];
    b       = ins[8] ? word_t'($signed(ins[7:0])) : model_regs[ins[1:0]];
    arith   = 1'b1;
    wide    = 0;
    exp_data = '0;
    case (op)
      OP_ADD: wide = int'(a) + int'(b);
      OP_SUB: wide = int'(a) - int'(b);
      OP_INC: wide = int'(a) + 1;
      default: arith = 1'b0;
    endcase
    case (op)
      OP_AND:  exp_data = a & b;
      OP_OR:   exp_data = a | b;
      OP_XOR:  exp_data = a ^ b;
      OP_MOVA: exp_data = a;
      OP_MOVB: exp_data = b;
      default: exp_data = word_t'(wide);
    endcase
    // true result outside the signed range
    ovf = arith && ((wide > WORD_MAX) || (wide < WORD_MIN));
    exp_flags = {ovf, exp_data[BW-1], exp_data == '0};
    model_regs[exp_reg] = exp_data;
  endtask

  // -------------------------------------------------------------------
  // compare tasks
  // -------------------------------------------------------------------
  task automatic check_wb(input reg_idx_t exp_reg, input word_t exp_data,
                          input flags_t exp_flags);
    checks++;
    if (wb_reg !== exp_reg || wb_data !== exp_data || wb_flags !== exp_flags) begin
      errors++;
      $display("FAILED at %0t: write-back r%0d = %0d flags %b, expected r%0d = %0d flags %b",
               $time, wb_reg, wb_data, wb_flags, exp_reg, exp_data, exp_flags);
    end
  endtask

  task automatic check_gap(input string what, input int exp_gap, input int got_gap);
    checks++;
    if (got_gap != exp_gap) begin
      errors++;
      $display("FAILED at %0t: %s is %0d cycles, expected %0d",
               $time, what, got_gap, exp_gap);
    end
  endtask

  task automatic check_done(input int exp_count, input int got_count, input int gap);
    checks++;
    if (gap != 1 || got_count != exp_count) begin
      errors++;
      $display({"FAILED at %0t: done %0d cycles after last write-back, ",
                "%0d write-backs, expected 1 and %0d"},
               $time, gap, got_count, exp_count);
    end
  endtask

  task automatic check_idle();
    checks++;
    if (busy !== 1'b0 || wb_valid !== 1'b0 || done !== 1'b0) begin
      errors++;
      $display("FAILED at %0t: core not idle, busy %b wb_valid %b done %b",
               $time, busy, wb_valid, done);
    end
  endtask

  // -------------------------------------------------------------------
  // program load and run
  // -------------------------------------------------------------------
  task automatic load_program(input instr_t prog [$]);
    foreach (prog[i]) begin
      prog_we   = 1'b1;
      prog_addr = pc_t'(i);
      prog_data = prog[i];
      tick();
    end
    prog_we = 1'b0;
  endtask

  // runs whatever the memory holds, prog is what it should hold
  task automatic run_program(input instr_t prog [$], input bit noisy);
    int       n_instr;
    int       wb_count;
    int       prev_wb;
    int       waited;
    string    gap_name;
    reg_idx_t exp_reg;
    word_t    exp_data;
    flags_t   exp_flags;
    n_instr  = prog.size();
    wb_count = 0;
    prog_len = pc_t'(n_instr - 1);
    start    = 1'b1;
    // first write-back is timed from the start pulse
    prev_wb  = cycle_cnt;
    tick();
    drive_noise(noisy);
    for (int i = 0; i < n_instr; i++) begin
      waited = 0;
      while (!wb_valid && waited < TIMEOUT_CYCLES) begin
        tick();
        drive_noise(noisy);
        waited++;
      end
      if (!wb_valid) begin
        timeouts++;
        $display("timeout: write-back %0d of %0d never arrived", i + 1, n_instr);
        drive_noise(1'b0);
        return;
      end
      if (i == 0) begin
        gap_name = "start to first write-back";
      end else begin
        gap_name = "write-back spacing";
      end
      check_gap(gap_name, WB_SPACING, cycle_cnt - prev_wb);
      prev_wb = cycle_cnt;
      wb_count++;
      model_exec(prog[i], exp_reg, exp_data, exp_flags);
      check_wb(exp_reg, exp_data, exp_flags);
      tick();
      drive_noise(noisy);
    end
    // any write-back seen here is one too many
    waited = 0;
    while (!done && waited < TIMEOUT_CYCLES) begin
      if (wb_valid) begin
        wb_count++;
      end
      tick();
      drive_noise(noisy);
      waited++;
    end
    drive_noise(1'b0);
    if (!done) begin
      timeouts++;
      $display("timeout: done never pulsed after the last write-back");
      return;
    end
    check_done(n_instr, wb_count, cycle_cnt - prev_wb);
    tick();
    check_idle();
  endtask

  // -------------------------------------------------------------------
  // test sequence
  // -------------------------------------------------------------------
  initial begin
    instr_t  prog [$];
    instr_t  ins;
    opcode_t op_seq;
    int      n_instr;
    clk       = 1'b0;
    rst_n     = 1'b0;
    prog_we   = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    prog_len  = '0;
    start     = 1'b0;
    op_seq    = '0;
    void'($urandom(73382));
    foreach (model_regs[i]) begin
      model_regs[i] = '0;
    end
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_idle();

    // immediate moves, plain, zero and negative results
    prog.delete();
    prog.push_back(encode(OP_MOVB, 2'd0, 2'd0, 1'b1, 8'd5));
    prog.push_back(encode(OP_MOVB, 2'd1, 2'd0, 1'b1, 8'd0));
    prog.push_back(encode(OP_MOVB, 2'd2, 2'd0, 1'b1, 8'hf9));
    prog.push_back(encode(OP_MOVA, 2'd3, 2'd0, 1'b0, 8'd0));
    load_program(prog);
    run_program(prog, 1'b0);

    // overflow corners, the and must not flag
    prog.delete();
    prog.push_back(encode(OP_MOVB, 2'd0, 2'd0, 1'b1, 8'h7f));
    prog.push_back(encode(OP_ADD,  2'd1, 2'd0, 1'b1, 8'd1));
    prog.push_back(encode(OP_MOVB, 2'd2, 2'd0, 1'b1, 8'h80));
    prog.push_back(encode(OP_SUB,  2'd3, 2'd2, 1'b1, 8'd1));
    prog.push_back(encode(OP_INC,  2'd1, 2'd0, 1'b0, 8'd0));
    prog.push_back(encode(OP_AND,  2'd3, 2'd0, 1'b1, 8'd1));
    prog.push_back(encode(OP_ADD,  2'd2, 2'd0, 1'b0, 8'd0));
    load_program(prog);
    run_program(prog, 1'b0);

    // random programs, opcodes rotated so all of them show up
    for (int p = 0; p < NUM_RAND_PROGS; p++) begin
      prog.delete();
      n_instr = 1 + int'($urandom % PROG_DEPTH);
      for (int i = 0; i < n_instr; i++) begin
        ins = instr_t'($urandom);
        ins[15:13] = op_seq;
        op_seq = op_seq + 3'd1;
        prog.push_back(ins);
      end
      load_program(prog);
      run_program(prog, 1'b0);
    end

    // start and writes while busy, then a rerun straight from memory
    prog.delete();
    for (int i = 0; i < PROG_DEPTH; i++) begin
      prog.push_back(instr_t'($urandom));
    end
    load_program(prog);
    run_program(prog, 1'b1);
    // no reload, memory must still hold the original words
    run_program(prog, 1'b0);

    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
hdl/isa_pkg.sv
hdl/core_pkg.sv
hdl/exec_if.sv
hdl/alu.sv
hdl/reg_file.sv
hdl/instr_mem.sv
hdl/program_counter.sv
hdl/core_ctrl.sv
hdl/alu_core.sv
dv/tb_alu_core.sv

// File: hdl/alu.sv
// alu combinational arithmetic and logic unit
// eight operations on one shared adder, overflow / negative / zero flags
`default_nettype none

module alu #(
  parameter int BW = 8
) (
  exec_if.alu x
);
  import isa_pkg::*;

  logic [BW-1:0] opnd_a;
  logic [BW-1:0] opnd_b;
  logic [BW-1:0] addend;
  logic          carry_in;
  logic [BW-1:0] sum;
  logic          is_arith;
  logic [BW-1:0] res;

  assign opnd_a = x.rd_a;
  // second operand from immediate or register b
  assign opnd_b = x.use_imm ? x.imm : x.rd_b;

  // -------------------------------------------------------------------
  // shared adder for add, sub and inc
  // -------------------------------------------------------------------
  always_comb begin
    addend   = opnd_b;
    carry_in = 1'b0;
    case (x.op)
      // a + ~b + 1
      OP_SUB: begin
        addend   = ~opnd_b;
        carry_in = 1'b1;
      end
      // b forced to one
      OP_INC: addend = {{(BW-1){1'b0}}, 1'b1};
      default: addend = opnd_b;
    endcase
  end

  assign sum = opnd_a + addend + {{(BW-1){1'b0}}, carry_in};

  assign is_arith = (x.op == OP_ADD) || (x.op == OP_SUB) || (x.op == OP_INC);

  // result select
  always_comb begin
    case (x.op)
      OP_AND:  res = opnd_a & opnd_b;
      OP_OR:   res = opnd_a | opnd_b;
      OP_XOR:  res = opnd_a ^ opnd_b;
      OP_MOVA: res = opnd_a;
      OP_MOVB: res = opnd_b;
      // add, sub, inc
      default: res = sum;
    endcase
  end

  assign x.result = res;

  // -------------------------------------------------------------------
  // flags
  // -------------------------------------------------------------------
  always_comb begin
    x.flags = '0;
    // same-sign inputs with a flipped sign out of the adder
    x.flags[FLAG_V] = is_arith && (opnd_a[BW-1] == addend[BW-1])
                      && (sum[BW-1] != opnd_a[BW-1]);
    x.flags[FLAG_N] = res[BW-1];
    x.flags[FLAG_Z] = (res == '0);
  end

endmodule

`default_nettype wire

// File: hdl/alu_core.sv
// alu_core multicycle execution core top level
// program memory, sequencer, register file and alu behind plain ports
`default_nettype none

module alu_core #(
  parameter int BW         = isa_pkg::BW,
  parameter int PROG_DEPTH = core_pkg::PROG_DEPTH
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               prog_we,
  input  core_pkg::pc_t      prog_addr,
  input  isa_pkg::instr_t    prog_data,
  input  core_pkg::pc_t      prog_len,
  input  logic               start,
  output logic               busy,
  output logic               wb_valid,
  output isa_pkg::reg_idx_t  wb_reg,
  output isa_pkg::word_t     wb_data,
  output isa_pkg::flags_t    wb_flags,
  output logic               done
);
  import isa_pkg::*;

  // fetched instruction from memory
  instr_t fetched;

  exec_if exec_bus (
    .clk   (clk),
    .rst_n (rst_n)
  );

  pc_if pc_bus ();

  // -------------------------------------------------------------------
  // control path
  // -------------------------------------------------------------------
  core_ctrl core_ctrl_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (start),
    .instr    (fetched),
    .x        (exec_bus.ctrl),
    .p        (pc_bus.ctrl),
    .busy     (busy),
    .wb_valid (wb_valid),
    .wb_reg   (wb_reg),
    .wb_data  (wb_data),
    .wb_flags (wb_flags),
    .done     (done)
  );

  program_counter #(
    .PROG_DEPTH (PROG_DEPTH)
  ) program_counter_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .prog_len (prog_len),
    .p        (pc_bus.counter)
  );

  // program store, writes locked out while busy
  instr_mem instr_mem_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .busy      (busy),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .rd_addr   (pc_bus.pc),
    .instr     (fetched)
  );

  // -------------------------------------------------------------------
  // datapath
  // -------------------------------------------------------------------
  reg_file reg_file_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .x     (exec_bus.regs)
  );

  alu #(
    .BW (BW)
  ) alu_inst (
    .x (exec_bus.alu)
  );

endmodule

`default_nettype wire

// File: hdl/core_ctrl.sv
// core_ctrl instruction sequencer
// fetch, execute and write-back fsm with instruction register and wb outputs
`default_nettype none

module core_ctrl (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               start,
  input  isa_pkg::instr_t    instr,
  exec_if.ctrl               x,
  pc_if.ctrl                 p,
  output logic               busy,
  output logic               wb_valid,
  output isa_pkg::reg_idx_t  wb_reg,
  output isa_pkg::word_t     wb_data,
  output isa_pkg::flags_t    wb_flags,
  output logic               done
);
  import isa_pkg::*;
  import core_pkg::*;

  ctrl_state_t state_q;
  ctrl_state_t state_d;
  instr_t      ir_q;
  instr_t      cur;

  // -------------------------------------------------------------------
  // state machine
  // -------------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:  if (start) state_d = FETCH;
      FETCH: state_d = EXEC;
      EXEC:  state_d = WB;
      WB:    state_d = p.last ? DONE : FETCH;
      DONE:  state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // -------------------------------------------------------------------
  // instruction register and decode
  // -------------------------------------------------------------------
  // memory output valid in exec, held here for wb
  always_ff @(posedge clk) begin
    if (state_q == EXEC) begin
      ir_q <= instr;
    end
  end

  assign cur = (state_q == EXEC) ? instr : ir_q;

  assign x.op      = cur[OPC_LSB +: $bits(opcode_t)];
  assign x.rd      = cur[RD_LSB +: $bits(reg_idx_t)];
  assign x.ra      = cur[RA_LSB +: $bits(reg_idx_t)];
  assign x.rb      = cur[RB_LSB +: $bits(reg_idx_t)];
  assign x.use_imm = cur[USE_IMM_BIT];
  // sign-extended immediate
  assign x.imm     = word_t'($signed(cur[IMM_LSB +: IMM_W]));

  // write-back capture at the end of exec
  always_ff @(posedge clk) begin
    if (state_q == EXEC) begin
      wb_reg   <= x.rd;
      wb_data  <= x.result;
      wb_flags <= x.flags;
    end
  end

  // strobes and pulses
  assign x.wr_en    = (state_q == WB);
  assign wb_valid   = (state_q == WB);
  assign done       = (state_q == DONE);
  assign busy       = (state_q != IDLE);
  assign p.clear    = (state_q == IDLE) && start;
  assign p.advance  = (state_q == WB) && !p.last;

endmodule

`default_nettype wire

// File: hdl/core_pkg.sv
// core_pkg microarchitecture definitions
// controller states, program depth and counter types
`default_nettype none

package core_pkg;

  // program memory depth in words
  localparam int PROG_DEPTH = 8;
  localparam int PC_W       = $clog2(PROG_DEPTH);

  // program address, also used for the program length
  typedef logic [PC_W-1:0] pc_t;

  // -------------------------------------------------------------------
  // controller sequence
  // -------------------------------------------------------------------
  // idle until start, then fetch / exec / wb per instruction
  // done for one cycle after the last write-back
  typedef enum logic [2:0] {
    IDLE  = 3'd0,
    FETCH = 3'd1,
    EXEC  = 3'd2,
    WB    = 3'd3,
    DONE  = 3'd4
  } ctrl_state_t;

endpackage

`default_nettype wire

// File: hdl/exec_if.sv
// exec_if and pc_if buses inside the core
// exec_if joins controller, register file and alu, pc_if the program counter
`default_nettype none

interface exec_if (
  input logic clk,
  input logic rst_n
);
  import isa_pkg::*;

  // decoded instruction fields
  opcode_t  op;
  reg_idx_t rd;
  reg_idx_t ra;
  reg_idx_t rb;
  logic     use_imm;
  word_t    imm;
  // register read data
  word_t    rd_a;
  word_t    rd_b;
  // alu outputs
  word_t    result;
  flags_t   flags;
  logic     wr_en;

  modport ctrl (input clk, rst_n, result, flags,
                output op, rd, ra, rb, use_imm, imm, wr_en);
  modport regs (input clk, rst_n, rd, ra, rb, wr_en, result,
                output rd_a, rd_b);
  modport alu  (input op, use_imm, imm, rd_a, rd_b,
                output result, flags);
endinterface

interface pc_if;
  import core_pkg::*;

  logic clear;
  logic advance;
  pc_t  pc;
  logic last;

  modport ctrl    (output clear, advance, input last);
  modport counter (input clear, advance, output pc, last);
endinterface

`default_nettype wire

// File: hdl/instr_mem.sv
// instr_mem program memory
// eight instruction words, host write while idle, registered read
`default_nettype none

module instr_mem (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             busy,
  input  logic             prog_we,
  input  core_pkg::pc_t    prog_addr,
  input  isa_pkg::instr_t  prog_data,
  input  core_pkg::pc_t    rd_addr,
  output isa_pkg::instr_t  instr
);
  import isa_pkg::*;
  import core_pkg::*;

  instr_t mem [PROG_DEPTH];
  logic   wr_ok;

  // host writes dropped while a program runs
  assign wr_ok = prog_we && !busy;

  always_ff @(posedge clk) begin
    if (wr_ok) begin
      mem[prog_addr] <= prog_data;
    end
  end

  // read data valid one cycle after the address
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      instr <= '0;
    end else begin
      instr <= mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

// File: hdl/isa_pkg.sv
// isa_pkg instruction set definitions
// operand width, opcodes, instruction word layout and flag bits
`default_nettype none

package isa_pkg;

  // -------------------------------------------------------------------
  // widths
  // -------------------------------------------------------------------
  // datapath width, top level passes it down as BW
  localparam int BW = 8;

  typedef logic signed [BW-1:0] word_t;
  typedef logic        [2:0]    opcode_t;
  typedef logic        [1:0]    reg_idx_t;
  // overflow, negative, zero
  typedef logic        [2:0]    flags_t;
  typedef logic        [15:0]   instr_t;

  // -------------------------------------------------------------------
  // opcodes
  // -------------------------------------------------------------------
  localparam opcode_t OP_ADD  = 3'd0;
  localparam opcode_t OP_SUB  = 3'd1;
  localparam opcode_t OP_AND  = 3'd2;
  localparam opcode_t OP_OR   = 3'd3;
  localparam opcode_t OP_XOR  = 3'd4;
  localparam opcode_t OP_INC  = 3'd5;
  localparam opcode_t OP_MOVA = 3'd6;
  localparam opcode_t OP_MOVB = 3'd7;

  // instruction fields, msb first
  // opcode(3) rd(2) ra(2) use_imm(1) imm_or_rb(8)
  localparam int OPC_LSB     = 13;
  localparam int RD_LSB      = 11;
  localparam int RA_LSB      = 9;
  localparam int USE_IMM_BIT = 8;
  localparam int IMM_LSB     = 0;
  localparam int IMM_W       = 8;
  // rb sits in the low bits of imm_or_rb
  localparam int RB_LSB      = 0;

  // flag bit positions inside flags_t
  localparam int FLAG_V = 2;
  localparam int FLAG_N = 1;
  localparam int FLAG_Z = 0;

endpackage

`default_nettype wire

// File: hdl/program_counter.sv
// program_counter instruction address
// clear, advance and last-instruction detect against the program length
`default_nettype none

module program_counter #(
  parameter int PROG_DEPTH = 8
) (
  input  logic           clk,
  input  logic           rst_n,
  input  core_pkg::pc_t  prog_len,
  pc_if.counter          p
);
  import core_pkg::*;

  // highest address in the memory
  localparam pc_t PC_MAX = pc_t'(PROG_DEPTH - 1);

  pc_t pc_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q <= '0;
    end else if (p.clear) begin
      pc_q <= '0;
    end else if (p.advance) begin
      // wrap at the end of memory
      pc_q <= (pc_q == PC_MAX) ? '0 : pc_t'(pc_q + 1'b1);
    end
  end

  assign p.pc = pc_q;
  // prog_len holds length minus one
  assign p.last = (pc_q == prog_len);

endmodule

`default_nettype wire

// File: hdl/reg_file.sv
// reg_file four-entry register file
// two combinational read ports and one write port
`default_nettype none

module reg_file (
  input logic  clk,
  input logic  rst_n,
  exec_if.regs x
);
  import isa_pkg::*;

  localparam int NUM_REGS = 4;

  // register storage
  word_t rf_q [NUM_REGS];

  // -------------------------------------------------------------------
  // write port
  // -------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        rf_q[i] <= '0;
      end
    end else if (x.wr_en) begin
      // alu result of the instruction in write-back
      rf_q[x.rd] <= x.result;
    end
  end

  // -------------------------------------------------------------------
  // read ports
  // -------------------------------------------------------------------
  // operand a
  assign x.rd_a = rf_q[x.ra];
  // operand b, ignored by the alu when use_imm is set
  assign x.rd_b = rf_q[x.rb];

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# compile and run the alu_core testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -j 0 --timescale 1ns/100ps --top-module tb_alu_core \
  -f flist.f -o sim_tb &&
  ./obj_dir/sim_tb | tee /dev/stderr | grep -q "Test completed successfully" &&
  echo "simulation passed" || { echo "simulation failed"; exit 1; }
